// ==== bench/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_ANY} outcome_e;

  typedef struct packed {
    logic [31:0] addr;
    logic        flush_first;
    outcome_e    outcome;
  } stim_t;

  localparam int          NUM_TESTS       = 20;
  localparam int          WATCHDOG_CYCLES = 20 * NUM_TESTS + 100;
  localparam logic [31:0] DATA_KEY        = 32'h5a5a0000;

  logic        clk_i;
  logic        rst_ni;
  fetch_req_t  fetch_req;
  logic        ready;
  fetch_rsp_t  fetch_rsp;
  refill_req_t refill_req;
  refill_rsp_t refill_rsp;
  logic        flush;
  logic        miss;

  string test_name [NUM_TESTS];
  stim_t stim      [NUM_TESTS];
  int    n_tests;
  // accepted fetches waiting for their response
  int    pend_idx_q [$];
  int    pend_cyc_q [$];
  bit    miss_seen;
  int    cycle_cnt;
  int    low_cycles;

  icache_top icache_top_i (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .fetch_req_i  ( fetch_req  ),
    .ready_o      ( ready      ),
    .fetch_rsp_o  ( fetch_rsp  ),
    .refill_req_o ( refill_req ),
    .refill_rsp_i ( refill_rsp ),
    .flush_i      ( flush      ),
    .miss_o       ( miss       )
  );

  tb_refill_mem tb_refill_mem_i (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .refill_req_i ( refill_req ),
    .refill_rsp_o ( refill_rsp )
  );

  always #50 clk_i = ~clk_i;

  // counted on the falling edge and read on the rising edge
  always @(negedge clk_i) cycle_cnt <= cycle_cnt + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic add_test(input string name, input logic [31:0] addr,
                          input logic flush_first, input outcome_e outcome);
    test_name[n_tests]        = name;
    stim[n_tests].addr        = addr;
    stim[n_tests].flush_first = flush_first;
    stim[n_tests].outcome     = outcome;
    n_tests++;
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic fill_table();
    add_test("first_fetch",  32'h0000_1004, 1'b0, EXP_MISS);
    // rest of the line streams back to back
    add_test("same_line_w0", 32'h0000_1000, 1'b0, EXP_HIT);
    add_test("same_line_w2", 32'h0000_1008, 1'b0, EXP_HIT);
    add_test("same_line_w3", 32'h0000_100c, 1'b0, EXP_HIT);
    // four tags in set 3 take the four empty ways
    add_test("set3_fill_a",  32'h0000_2030, 1'b0, EXP_MISS);
    add_test("set3_fill_b",  32'h0000_3030, 1'b0, EXP_MISS);
    add_test("set3_fill_c",  32'h0000_4030, 1'b0, EXP_MISS);
    add_test("set3_fill_d",  32'h0000_5030, 1'b0, EXP_MISS);
    add_test("set3_hit_a",   32'h0000_2034, 1'b0, EXP_HIT);
    add_test("set3_hit_b",   32'h0000_3038, 1'b0, EXP_HIT);
    add_test("set3_hit_c",   32'h0000_403c, 1'b0, EXP_HIT);
    add_test("set3_hit_d",   32'h0000_5030, 1'b0, EXP_HIT);
    // full set loses one line
    add_test("set3_fifth",   32'h0000_6030, 1'b0, EXP_MISS);
    add_test("set3_again_a", 32'h0000_2030, 1'b0, EXP_ANY);
    add_test("set3_again_b", 32'h0000_3034, 1'b0, EXP_ANY);
    add_test("set3_again_c", 32'h0000_4038, 1'b0, EXP_ANY);
    add_test("set3_again_d", 32'h0000_503c, 1'b0, EXP_ANY);
    add_test("set3_again_e", 32'h0000_6034, 1'b0, EXP_ANY);
    add_test("after_flush",  32'h0000_1004, 1'b1, EXP_MISS);
    add_test("refilled",     32'h0000_1008, 1'b0, EXP_HIT);
  endtask

  ////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    int cur;
    int acc;
    // miss strobe and refill request come as a pair
    if (miss || refill_req.valid) begin
      if (pend_idx_q.size() == 0) begin
        abort_run("a refill was requested while no fetch was outstanding");
      end else begin
        cur = pend_idx_q[0];
        check_value({test_name[cur], "_miss"}, 32'd1, 32'(miss));
        check_value({test_name[cur], "_refill"}, 32'd1, 32'(refill_req.valid));
        // one refill per fetch
        check_value({test_name[cur], "_refill_count"}, 32'd0, 32'(miss_seen));
        check_value(test_name[cur], {stim[cur].addr[31:4], 4'h0}, refill_req.addr);
        check_value(test_name[cur], 32'd0, 32'(ready));
        miss_seen = 1'b1;
      end
    end
    if (fetch_rsp.valid) begin
      if (pend_idx_q.size() == 0) begin
        abort_run("a fetch response arrived while no fetch was outstanding");
      end else begin
        cur = pend_idx_q.pop_front();
        acc = pend_cyc_q.pop_front();
        check_value(test_name[cur], stim[cur].addr ^ DATA_KEY, fetch_rsp.data);
        check_value(test_name[cur], stim[cur].addr, fetch_rsp.addr.raw);
        if (stim[cur].outcome == EXP_HIT) begin
          check_value(test_name[cur], 32'd0, 32'(miss_seen));
          // hit word one cycle after acceptance
          check_value(test_name[cur], 32'd1, cycle_cnt - acc);
          // next request may be taken while the hit responds
          check_value({test_name[cur], "_ready"}, 32'd1, 32'(ready));
        end else if (stim[cur].outcome == EXP_MISS) begin
          check_value(test_name[cur], 32'd1, 32'(miss_seen));
        end
        miss_seen = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // driver
  ////////////////////////////////////////

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    fetch_req  = '0;
    flush      = 1'b0;
    n_tests    = 0;
    miss_seen  = 1'b0;
    cycle_cnt  = 0;
    fill_table();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // reset sweep covers every set
    low_cycles = 0;
    while (!ready) begin
      low_cycles++;
      @(negedge clk_i);
    end
    check_value("reset_sweep", NUM_SETS, low_cycles);

    for (int i = 0; i < NUM_TESTS; i++) begin
      if (stim[i].flush_first) begin
        fetch_req.req = 1'b0;
        while (pend_idx_q.size() != 0) @(negedge clk_i);
        flush = 1'b1;
        @(negedge clk_i);
        flush = 1'b0;
        // one cycle to leave IDLE before the sweep
        low_cycles = 0;
        while (!ready) begin
          low_cycles++;
          @(negedge clk_i);
        end
        check_value({test_name[i], "_flush"}, NUM_SETS + 1, low_cycles);
      end
      fetch_req.req      = 1'b1;
      fetch_req.addr.raw = stim[i].addr;
      @(posedge clk_i);
      while (!ready) @(posedge clk_i);
      pend_idx_q.push_back(i);
      pend_cyc_q.push_back(cycle_cnt);
      @(negedge clk_i);
      fetch_req.req = 1'b0;
    end

    while (pend_idx_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
    $display("TEST PASS");
    $finish;
  end

  // run limit scaled by the table length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog expired before all fetches were answered");
  end

endmodule

// ==== bench/tb_refill_mem.sv ====
`timescale 1ns/1ps

module tb_refill_mem import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  refill_req_t refill_req_i,
  output refill_rsp_t refill_rsp_o
);

  // word at byte address A holds A ^ DATA_KEY
  localparam logic [31:0] DATA_KEY = 32'h5a5a0000;

  logic [31:0] rng_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // whole line built word by word from its byte address
  function automatic logic [LINE_WIDTH-1:0] line_at(input logic [ADDR_WIDTH-1:0] base);
    logic [LINE_WIDTH-1:0] line;
    for (int w = 0; w < LINE_WIDTH / FETCH_WIDTH; w++) begin
      line[w*FETCH_WIDTH +: FETCH_WIDTH] = (base + ADDR_WIDTH'(4 * w)) ^ DATA_KEY;
    end
    return line;
  endfunction

  // request seen mid-cycle is answered 1 to 8 cycles later for one cycle
  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    int unsigned           delay;
    refill_rsp_o = '0;
    rng_q        = 32'h7e64;
    forever begin
      @(negedge clk_i);
      if (rst_ni && refill_req_i.valid) begin
        addr  = refill_req_i.addr;
        rng_q = xorshift(rng_q);
        delay = 1 + (rng_q % 8);
        repeat (delay) @(negedge clk_i);
        refill_rsp_o.valid = 1'b1;
        refill_rsp_o.data  = line_at(addr);
        @(negedge clk_i);
        refill_rsp_o = '0;
      end
    end
  end

endmodule

// ==== compile.f ====
source/icache_pkg.sv
source/fetch_ctrl.sv
source/tag_store.sv
source/victim_select.sv
source/data_store.sv
source/icache_top.sv
bench/tb_refill_mem.sv
bench/tb_icache.sv

// ==== run.sh ====
#!/bin/bash
# build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_icache -f compile.f \
  -o sim_icache > build.log 2>&1 \
  || { cat build.log; echo "verilator build did not complete"; exit 1; }

./obj_dir/sim_icache > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== source/data_store.sv ====
`timescale 1ns/1ps

module data_store import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lookup_i,
  input  logic [INDEX_WIDTH-1:0]    index_i,
  input  logic                      write_i,
  input  way_mask_t                 way_sel_i,
  input  logic [LINE_WIDTH-1:0]     refill_line_i,
  input  logic [WAY_WIDTH-1:0]      hit_way_i,
  input  logic [WORD_OFF_WIDTH-1:0] offset_i,
  input  logic                      from_refill_i,
  output logic [FETCH_WIDTH-1:0]    data_o
);

  // one line per way and set
  logic [LINE_WIDTH-1:0] line_mem [NUM_WAYS][NUM_SETS];
  // lines of all ways for the set under lookup
  logic [LINE_WIDTH-1:0] line_rd [NUM_WAYS];
  // line the word comes from
  logic [LINE_WIDTH-1:0] sel_line;

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  // refill writes only the victim way
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way_sel_i[w]) begin
          line_mem[w][index_i] <= refill_line_i;
        end
      end
    end
  end

  // speculative read of every way before the tag compare picks one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        line_rd[w] <= '0;
      end
    end else if (lookup_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        line_rd[w] <= line_mem[w][index_i];
      end
    end
  end

  ////////////////////////////////////////
  // word select
  ////////////////////////////////////////

  // on a miss the word bypasses the array straight from the refill beat
  assign sel_line = from_refill_i ? refill_line_i : line_rd[hit_way_i];
  assign data_o   = sel_line[offset_i * FETCH_WIDTH +: FETCH_WIDTH];

endmodule

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  fetch_req_t                fetch_req_i,
  input  logic                      flush_i,
  input  logic                      refill_rsp_valid_i,
  input  logic                      hit_i,
  input  way_mask_t                 victim_i,
  output logic                      ready_o,
  output logic                      rsp_valid_o,
  output fetch_addr_u               rsp_addr_o,
  output refill_req_t               refill_req_o,
  output logic                      miss_o,
  output logic                      lookup_o,
  output logic [INDEX_WIDTH-1:0]    index_o,
  output logic [TAG_WIDTH-1:0]      tag_o,
  output logic [WORD_OFF_WIDTH-1:0] offset_o,
  output logic                      write_o,
  output logic                      clear_o,
  output way_mask_t                 way_sel_o,
  output logic                      from_refill_o,
  output logic                      replace_o
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e                 state_d, state_q;
  // flush strobe held until the sweep finishes
  logic                   flush_q;
  logic [INDEX_WIDTH-1:0] flush_cnt_q;
  logic                   flush_done;
  // request under lookup or refill
  fetch_addr_u            addr_q;
  // victim picked during READ
  way_mask_t              way_sel_q;

  // last set of the sweep
  assign flush_done = (state_q == FLUSH) && (flush_cnt_q == INDEX_WIDTH'(NUM_SETS - 1));

  ////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    ready_o            = 1'b0;
    lookup_o           = 1'b0;
    rsp_valid_o        = 1'b0;
    refill_req_o.valid = 1'b0;
    // line-aligned refill address
    refill_req_o.addr  = {addr_q.raw[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    miss_o             = 1'b0;
    write_o            = 1'b0;
    clear_o            = 1'b0;
    unique case (state_q)
      // wipe one set per cycle
      FLUSH: begin
        clear_o = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      // pending flush wins over a new request
      IDLE: begin
        if (flush_q) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (fetch_req_i.req) begin
            lookup_o = 1'b1;
            state_d  = READ;
          end
        end
      end
      // arrays were read at the accepting edge so compare now
      READ: begin
        if (hit_i) begin
          rsp_valid_o = 1'b1;
          state_d     = IDLE;
          if (flush_q) begin
            state_d = FLUSH;
          end else begin
            // next lookup overlaps this response
            ready_o = 1'b1;
            if (fetch_req_i.req) begin
              lookup_o = 1'b1;
              state_d  = READ;
            end
          end
        end else begin
          // single refill that memory always takes
          refill_req_o.valid = 1'b1;
          miss_o             = 1'b1;
          state_d            = MISS;
        end
      end
      // line comes back after a variable delay
      MISS: begin
        if (refill_rsp_valid_i) begin
          rsp_valid_o = 1'b1;
          write_o     = 1'b1;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////
  // array addressing
  ////////////////////////////////////////

  // sweep index while flushing and held index for the refill write
  // otherwise the index goes straight from the incoming request
  always_comb begin
    unique case (state_q)
      FLUSH:   index_o = flush_cnt_q;
      MISS:    index_o = addr_q.fields.index;
      default: index_o = fetch_req_i.addr.fields.index;
    endcase
  end

  assign tag_o      = addr_q.fields.tag;
  assign offset_o   = addr_q.fields.word;
  assign rsp_addr_o = addr_q;
  assign way_sel_o  = way_sel_q;

  // response word taken from the refill beat while waiting
  assign from_refill_o = (state_q == MISS);

  // each refill write is offered and the LFSR only steps on a full set
  assign replace_o = write_o;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      way_sel_q   <= '0;
    end else begin
      state_q <= state_d;
      // a strobe on the last sweep cycle stays pending
      flush_q <= (flush_q & ~flush_done) | flush_i;
      if (flush_done) begin
        flush_cnt_q <= '0;
      end else if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      // victim is stable until the refill lands
      if (state_q == READ) begin
        way_sel_q <= victim_i;
      end
    end
  end

  // request address loaded on accept
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      addr_q <= fetch_req_i.addr;
    end
  end

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  // physical byte address and fetched word
  localparam int ADDR_WIDTH   = 32;
  localparam int FETCH_WIDTH  = 32;
  // one line per refill
  localparam int LINE_WIDTH   = 128;

  // four ways of sixteen sets
  localparam int NUM_WAYS     = 4;
  localparam int WAY_WIDTH    = $clog2(NUM_WAYS);
  localparam int NUM_SETS     = 16;
  localparam int INDEX_WIDTH  = $clog2(NUM_SETS);

  // byte offset inside a line splits into word select and byte-in-word
  localparam int OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
  localparam int BYTE_OFF_WIDTH = $clog2(FETCH_WIDTH / 8);
  localparam int WORD_OFF_WIDTH = OFFSET_WIDTH - BYTE_OFF_WIDTH;

  // whatever is left above index and offset
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  ////////////////////////////////////////
  // address views
  ////////////////////////////////////////

  // split view used for array indexing and tag compare
  typedef struct packed {
    logic [TAG_WIDTH-1:0]      tag;
    logic [INDEX_WIDTH-1:0]    index;
    logic [WORD_OFF_WIDTH-1:0] word;
    logic [BYTE_OFF_WIDTH-1:0] byte_sel;
  } addr_fields_t;

  // raw view feeds the refill line address
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    addr_fields_t          fields;
  } fetch_addr_u;

  ////////////////////////////////////////
  // port bundles
  ////////////////////////////////////////

  // core to cache request qualified by ready_o
  typedef struct packed {
    logic        req;
    fetch_addr_u addr;
  } fetch_req_t;

  // single-cycle response strobe from cache to core
  typedef struct packed {
    logic                   valid;
    logic [FETCH_WIDTH-1:0] data;
    fetch_addr_u            addr;
  } fetch_rsp_t;

  // line-aligned refill request without acknowledge
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
  } refill_req_t;

  // whole line comes back in one beat
  typedef struct packed {
    logic                  valid;
    logic [LINE_WIDTH-1:0] data;
  } refill_rsp_t;

  // one bit per way
  typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage

// ==== source/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // fetch side
  input  fetch_req_t  fetch_req_i,
  output logic        ready_o,
  output fetch_rsp_t  fetch_rsp_o,
  // refill side
  output refill_req_t refill_req_o,
  input  refill_rsp_t refill_rsp_i,
  // control and status
  input  logic        flush_i,
  output logic        miss_o
);

  // array control from the FSM
  logic                      lookup;
  logic                      write;
  logic                      clear;
  logic [INDEX_WIDTH-1:0]    index;
  logic [TAG_WIDTH-1:0]      tag;
  logic [WORD_OFF_WIDTH-1:0] offset;
  way_mask_t                 way_sel;
  logic                      from_refill;
  logic                      replace;

  // lookup results
  logic                      hit;
  logic [WAY_WIDTH-1:0]      hit_way;
  way_mask_t                 valid;
  way_mask_t                 victim;

  // response fields
  logic                      rsp_valid;
  fetch_addr_u               rsp_addr;
  logic [FETCH_WIDTH-1:0]    rsp_data;

  assign fetch_rsp_o.valid = rsp_valid;
  assign fetch_rsp_o.data  = rsp_data;
  assign fetch_rsp_o.addr  = rsp_addr;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  fetch_ctrl fetch_ctrl_i (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .fetch_req_i        ( fetch_req_i        ),
    .flush_i            ( flush_i            ),
    .refill_rsp_valid_i ( refill_rsp_i.valid ),
    .hit_i              ( hit                ),
    .victim_i           ( victim             ),
    .ready_o            ( ready_o            ),
    .rsp_valid_o        ( rsp_valid          ),
    .rsp_addr_o         ( rsp_addr           ),
    .refill_req_o       ( refill_req_o       ),
    .miss_o             ( miss_o             ),
    .lookup_o           ( lookup             ),
    .index_o            ( index              ),
    .tag_o              ( tag                ),
    .offset_o           ( offset             ),
    .write_o            ( write              ),
    .clear_o            ( clear              ),
    .way_sel_o          ( way_sel            ),
    .from_refill_o      ( from_refill        ),
    .replace_o          ( replace            )
  );

  ////////////////////////////////////////
  // tags and replacement
  ////////////////////////////////////////

  tag_store tag_store_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .lookup_i  ( lookup  ),
    .index_i   ( index   ),
    .tag_i     ( tag     ),
    .write_i   ( write   ),
    .clear_i   ( clear   ),
    .way_sel_i ( way_sel ),
    .hit_o     ( hit     ),
    .hit_way_o ( hit_way ),
    .valid_o   ( valid   )
  );

  victim_select victim_select_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .valid_i   ( valid   ),
    .replace_i ( replace ),
    .victim_o  ( victim  )
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  data_store data_store_i (
    .clk_i         ( clk_i             ),
    .rst_ni        ( rst_ni            ),
    .lookup_i      ( lookup            ),
    .index_i       ( index             ),
    .write_i       ( write             ),
    .way_sel_i     ( way_sel           ),
    .refill_line_i ( refill_rsp_i.data ),
    .hit_way_i     ( hit_way           ),
    .offset_i      ( offset            ),
    .from_refill_i ( from_refill       ),
    .data_o        ( rsp_data          )
  );

endmodule

// ==== source/tag_store.sv ====
`timescale 1ns/1ps

module tag_store import icache_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lookup_i,
  input  logic [INDEX_WIDTH-1:0] index_i,
  input  logic [TAG_WIDTH-1:0]   tag_i,
  input  logic                   write_i,
  input  logic                   clear_i,
  input  way_mask_t              way_sel_i,
  output logic                   hit_o,
  output logic [WAY_WIDTH-1:0]   hit_way_o,
  output way_mask_t              valid_o
);

  // tag per way and set
  logic [TAG_WIDTH-1:0] tag_mem [NUM_WAYS][NUM_SETS];
  // valid bits of all ways with one word per set
  way_mask_t            valid_mem [NUM_SETS];

  // synchronous read data
  logic [TAG_WIDTH-1:0] tag_rd [NUM_WAYS];
  way_mask_t            valid_rd;
  way_mask_t            match;

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // flush clears every way of one set
    if (clear_i) begin
      valid_mem[index_i] <= '0;
    end
    // refill sets tag and valid of the victim way
    if (write_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way_sel_i[w]) begin
          tag_mem[w][index_i]   <= tag_i;
          valid_mem[index_i][w] <= 1'b1;
        end
      end
    end
    // all ways read together
    if (lookup_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_rd[w] <= tag_mem[w][index_i];
      end
    end
  end

  // valid read data stays until the next lookup so the victim choice sees it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_rd <= '0;
    end else if (lookup_i) begin
      valid_rd <= valid_mem[index_i];
    end
  end

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_rd[w] && (tag_rd[w] == tag_i);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_way_o = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way_o = WAY_WIDTH'(w);
      end
    end
  end

  assign hit_o   = |match;
  assign valid_o = valid_rd;

endmodule

// ==== source/victim_select.sv ====
`timescale 1ns/1ps

module victim_select import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  way_mask_t valid_i,
  input  logic      replace_i,
  output way_mask_t victim_o
);

  logic                 all_valid;
  logic [WAY_WIDTH-1:0] inv_way;
  logic [WAY_WIDTH-1:0] repl_way;
  logic [WAY_WIDTH-1:0] lfsr_q;

  assign all_valid = &valid_i;

  // first empty way, lowest index first
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = WAY_WIDTH'(w);
      end
    end
  end

  ////////////////////////////////////////
  // random replacement
  ////////////////////////////////////////

  // x^2 + x + 1 runs through 01 11 10
  // only steps when a full set loses a line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= WAY_WIDTH'(1);
    end else if (replace_i && all_valid) begin
      lfsr_q <= {lfsr_q[0], lfsr_q[1] ^ lfsr_q[0]};
    end
  end

  assign repl_way = all_valid ? lfsr_q : inv_way;

  // one-hot for the array write enables
  assign victim_o = way_mask_t'(1) << repl_way;

endmodule
